/* isa_pkg.sv */
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_INST   = 48;
    localparam int ECODE_W    = 7;

    //////////////////////////////////////////////////////////////////////
    // instruction flag positions
    //////////////////////////////////////////////////////////////////////

    // 17-bit opcode group, same order as OP17
    localparam int
        I_ADD  = 0,  I_SUB  = 1,  I_SLT  = 2,  I_SLTU  = 3,  I_NOR     = 4,
        I_AND  = 5,  I_OR   = 6,  I_XOR  = 7,  I_SLL   = 8,  I_SRL     = 9,
        I_SRA  = 10, I_MUL  = 11, I_MULH = 12, I_MULHU = 13, I_DIV     = 14,
        I_MOD  = 15, I_DIVU = 16, I_MODU = 17, I_BREAK = 18, I_SYSCALL = 19,
        I_SLLI = 20, I_SRLI = 21, I_SRAI = 22;
    // 10-bit opcode group
    localparam int
        I_SLTI = 23, I_SLTUI = 24, I_ADDI = 25, I_ANDI = 26, I_ORI = 27,
        I_XORI = 28, I_LDB   = 29, I_LDH  = 30, I_LDW  = 31, I_STB = 32,
        I_STH  = 33, I_STW   = 34, I_LDBU = 35, I_LDHU = 36;
    // 7-bit and 6-bit groups
    localparam int
        I_LU12I = 37, I_PCADDU12I = 38,
        I_JIRL  = 39, I_B   = 40, I_BL   = 41, I_BEQ  = 42, I_BNE = 43,
        I_BLT   = 44, I_BGE = 45, I_BLTU = 46, I_BGEU = 47;

    localparam int N_OP17    = 23;
    localparam int N_OP10    = 14;
    localparam int N_OP7     = 2;
    localparam int N_OP6     = 9;
    localparam int BASE_OP10 = I_SLTI;
    localparam int BASE_OP7  = I_LU12I;
    localparam int BASE_OP6  = I_JIRL;

    //////////////////////////////////////////////////////////////////////
    // opcode patterns, indexed from the base of each group
    //////////////////////////////////////////////////////////////////////

    localparam logic [16:0] OP17 [N_OP17] = '{
        17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029,
        17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030, 17'h00038,
        17'h00039, 17'h0003a, 17'h00040, 17'h00041, 17'h00042, 17'h00043,
        17'h00054, 17'h00056, 17'h00081, 17'h00089, 17'h00091
    };
    localparam logic [9:0] OP10 [N_OP10] = '{
        10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f, 10'h0a0,
        10'h0a1, 10'h0a2, 10'h0a4, 10'h0a5, 10'h0a6, 10'h0a8, 10'h0a9
    };
    localparam logic [6:0] OP7 [N_OP7] = '{7'h0a, 7'h0e};
    localparam logic [5:0] OP6 [N_OP6] = '{
        6'h13, 6'h14, 6'h15, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b
    };

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm20;
            logic [4:0]  rd;
        } u20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo16;
            logic [9:0]  offs_hi10;
        } of26;
    } inst_word_t;

    localparam logic [ECODE_W-1:0] ECODE_NONE = 7'h00;
    localparam logic [ECODE_W-1:0] ECODE_SYS  = 7'h0b;
    localparam logic [ECODE_W-1:0] ECODE_BRK  = 7'h0c;
    localparam logic [ECODE_W-1:0] ECODE_INE  = 7'h0d;

endpackage

/* ctrl_pkg.sv */
package ctrl_pkg;

    localparam int ALU_OP_W  = 12;
    localparam int SRC_SEL_W = 4;
    localparam int BR_TYPE_W = 4;
    localparam int LDST_W    = 4;
    localparam int WB_SEL_W  = 6;
    localparam int CLASS_W   = 4;

    // one-hot alu operation
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 12'h001;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 12'h002;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 12'h004;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 12'h008;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 12'h010;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 12'h020;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 12'h040;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 12'h080;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 12'h100;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 12'h200;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 12'h400;
    localparam logic [ALU_OP_W-1:0] ALU_NONE = 12'h800;

    // operand sources
    localparam logic [SRC_SEL_W-1:0] SRC1_PC   = 4'h1;
    localparam logic [SRC_SEL_W-1:0] SRC1_RF   = 4'h2;
    localparam logic [SRC_SEL_W-1:0] SRC1_ZERO = 4'h4;
    localparam logic [SRC_SEL_W-1:0] SRC2_IMM  = 4'h1;
    localparam logic [SRC_SEL_W-1:0] SRC2_RF   = 4'h2;
    localparam logic [SRC_SEL_W-1:0] SRC2_FOUR = 4'h4;

    localparam logic [BR_TYPE_W-1:0] BR_NONE = 4'h0;
    localparam logic [BR_TYPE_W-1:0] BR_JIRL = 4'h3;
    localparam logic [BR_TYPE_W-1:0] BR_B    = 4'h4;
    localparam logic [BR_TYPE_W-1:0] BR_BL   = 4'h5;
    localparam logic [BR_TYPE_W-1:0] BR_BEQ  = 4'h6;
    localparam logic [BR_TYPE_W-1:0] BR_BNE  = 4'h7;
    localparam logic [BR_TYPE_W-1:0] BR_BLT  = 4'h8;
    localparam logic [BR_TYPE_W-1:0] BR_BGE  = 4'h9;
    localparam logic [BR_TYPE_W-1:0] BR_BLTU = 4'ha;
    localparam logic [BR_TYPE_W-1:0] BR_BGEU = 4'hb;

    localparam logic [LDST_W-1:0] LDST_W_LD  = 4'h0;
    localparam logic [LDST_W-1:0] LDST_W_ST  = 4'h1;
    localparam logic [LDST_W-1:0] LDST_B_LD  = 4'h2;
    localparam logic [LDST_W-1:0] LDST_H_LD  = 4'h3;
    localparam logic [LDST_W-1:0] LDST_BU_LD = 4'h4;
    localparam logic [LDST_W-1:0] LDST_HU_LD = 4'h5;
    localparam logic [LDST_W-1:0] LDST_B_ST  = 4'h6;
    localparam logic [LDST_W-1:0] LDST_H_ST  = 4'h7;
    localparam logic [LDST_W-1:0] LDST_OTHER = 4'h8;

    // one-hot writeback source
    localparam logic [WB_SEL_W-1:0] WB_ALU  = 6'h01;
    localparam logic [WB_SEL_W-1:0] WB_LD   = 6'h02;
    localparam logic [WB_SEL_W-1:0] WB_MUL  = 6'h04;
    localparam logic [WB_SEL_W-1:0] WB_MULH = 6'h08;
    localparam logic [WB_SEL_W-1:0] WB_DIV  = 6'h10;
    localparam logic [WB_SEL_W-1:0] WB_MOD  = 6'h20;

    localparam logic [CLASS_W-1:0] CLASS_OTHER = 4'h1;
    localparam logic [CLASS_W-1:0] CLASS_LDST  = 4'h2;
    localparam logic [CLASS_W-1:0] CLASS_MUL   = 4'h4;
    localparam logic [CLASS_W-1:0] CLASS_DIV   = 4'h8;

endpackage

/* inst_match.sv */
`timescale 1ns/1ps

module inst_match
    import isa_pkg::*;
(
    input  inst_word_t          i_inst,
    output logic [NUM_INST-1:0] o_flags,
    output logic                o_lawful
);

    // 17-bit opcode spans the register view's opcode and top of imm12
    logic [16:0] op17;

    assign op17 = {i_inst.ri.opcode, i_inst.ri.imm12[11:5]};

    always_comb begin
        o_flags = '0;
        for (int k = 0; k < N_OP17; k++) begin
            o_flags[k] = (op17 == OP17[k]);
        end
        for (int k = 0; k < N_OP10; k++) begin
            o_flags[BASE_OP10 + k] = (i_inst.ri.opcode == OP10[k]);
        end
        for (int k = 0; k < N_OP7; k++) begin
            o_flags[BASE_OP7 + k] = (i_inst.u20.opcode == OP7[k]);
        end
        for (int k = 0; k < N_OP6; k++) begin
            o_flags[BASE_OP6 + k] = (i_inst.of26.opcode == OP6[k]);
        end
    end

    // patterns never overlap, so at most one flag is set
    assign o_lawful = |o_flags;

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import isa_pkg::*;
(
    input  inst_word_t          i_inst,
    input  logic [NUM_INST-1:0] i_flags,
    output logic [XLEN-1:0]     o_imm
);

    logic is_offs16;
    logic is_offs26;
    logic is_simm12;
    logic is_uimm12;
    logic is_imm20;
    logic is_shamt;

    // format groups
    assign is_offs16 = i_flags[I_JIRL] | (|i_flags[I_BGEU:I_BEQ]);
    assign is_offs26 = i_flags[I_B] | i_flags[I_BL];
    // slti, sltui, addi and every load and store
    assign is_simm12 = (|i_flags[I_ADDI:I_SLTI]) | (|i_flags[I_LDHU:I_LDB]);
    assign is_uimm12 = |i_flags[I_XORI:I_ANDI];
    assign is_imm20  = i_flags[I_LU12I] | i_flags[I_PCADDU12I];
    assign is_shamt  = |i_flags[I_SRAI:I_SLLI];

    always_comb begin
        if (is_offs16) begin
            o_imm = {{14{i_inst.of26.offs_lo16[15]}}, i_inst.of26.offs_lo16, 2'b00};
        end else if (is_offs26) begin
            // hi10 sits in the low bits of the word but is the upper part
            o_imm = {{4{i_inst.of26.offs_hi10[9]}}, i_inst.of26.offs_hi10,
                     i_inst.of26.offs_lo16, 2'b00};
        end else if (is_simm12) begin
            o_imm = {{20{i_inst.ri.imm12[11]}}, i_inst.ri.imm12};
        end else if (is_uimm12) begin
            o_imm = {20'd0, i_inst.ri.imm12};
        end else if (is_imm20) begin
            o_imm = {i_inst.u20.imm20, 12'h000};
        end else if (is_shamt) begin
            o_imm = {27'd0, i_inst.ri.imm12[4:0]};
        end else begin
            o_imm = '0;
        end
    end

endmodule

/* ctrl_gen.sv */
`timescale 1ns/1ps

module ctrl_gen
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  inst_word_t            i_inst,
    input  logic [NUM_INST-1:0]   i_flags,
    input  logic                  i_lawful,
    input  logic                  i_valid,
    output logic [ALU_OP_W-1:0]   o_alu_op,
    output logic [SRC_SEL_W-1:0]  o_src1_sel,
    output logic [SRC_SEL_W-1:0]  o_src2_sel,
    output logic [BR_TYPE_W-1:0]  o_br_type,
    output logic [LDST_W-1:0]     o_ldst_type,
    output logic                  o_mem_we,
    output logic [WB_SEL_W-1:0]   o_wb_sel,
    output logic [CLASS_W-1:0]    o_inst_class,
    output logic                  o_sign,
    output logic [REG_ADDR_W-1:0] o_rf_raddr1,
    output logic [REG_ADDR_W-1:0] o_rf_raddr2,
    output logic [REG_ADDR_W-1:0] o_rf_rd,
    output logic                  o_rf_we
);

    logic                 is_load;
    logic                 is_store;
    logic                 is_cbr;
    logic                 is_mul;
    logic                 is_div;
    logic                 use_imm;
    logic                 use_rf;
    logic [BR_TYPE_W-1:0] br_raw;

    assign is_load  = (|i_flags[I_LDW:I_LDB]) | i_flags[I_LDBU] | i_flags[I_LDHU];
    assign is_store = |i_flags[I_STW:I_STB];
    assign is_cbr   = |i_flags[I_BGEU:I_BEQ];
    assign is_mul   = |i_flags[I_MULHU:I_MUL];
    assign is_div   = |i_flags[I_MODU:I_DIV];

    //////////////////////////////////////////////////////////////////////
    // alu and operand selection
    //////////////////////////////////////////////////////////////////////

    assign o_alu_op =
        (i_flags[I_ADD] | i_flags[I_ADDI] | is_load | is_store | i_flags[I_PCADDU12I]
         | i_flags[I_LU12I] | i_flags[I_BL] | i_flags[I_JIRL])         ? ALU_ADD  :
        (i_flags[I_SUB] | i_flags[I_BEQ] | i_flags[I_BNE])             ? ALU_SUB  :
        (i_flags[I_SLT] | i_flags[I_SLTI] | i_flags[I_BLT] | i_flags[I_BGE]) ? ALU_SLT :
        (i_flags[I_SLTU] | i_flags[I_SLTUI] | i_flags[I_BLTU]
         | i_flags[I_BGEU])                                            ? ALU_SLTU :
        (i_flags[I_AND] | i_flags[I_ANDI])                             ? ALU_AND  :
        (i_flags[I_OR] | i_flags[I_ORI])                               ? ALU_OR   :
        (i_flags[I_NOR])                                               ? ALU_NOR  :
        (i_flags[I_XOR] | i_flags[I_XORI])                             ? ALU_XOR  :
        (i_flags[I_SLL] | i_flags[I_SLLI])                             ? ALU_SLL  :
        (i_flags[I_SRL] | i_flags[I_SRLI])                             ? ALU_SRL  :
        (i_flags[I_SRA] | i_flags[I_SRAI])                             ? ALU_SRA  : ALU_NONE;

    assign o_src1_sel = (i_flags[I_BL] | i_flags[I_PCADDU12I] | i_flags[I_JIRL]) ? SRC1_PC :
                        (i_flags[I_LU12I]) ? SRC1_ZERO : SRC1_RF;

    // imm for the 10-bit group, immediate shifts and the 20-bit forms
    assign use_imm = (|i_flags[I_LDHU:I_SLTI]) | (|i_flags[I_SRAI:I_SLLI])
                   | i_flags[I_LU12I] | i_flags[I_PCADDU12I];
    // register-register alu, mul/div and compare branches
    assign use_rf  = (|i_flags[I_MODU:I_ADD]) | is_cbr;

    // link address is pc + 4
    assign o_src2_sel = use_imm ? SRC2_IMM : use_rf ? SRC2_RF : SRC2_FOUR;

    //////////////////////////////////////////////////////////////////////
    // branch, memory and writeback
    //////////////////////////////////////////////////////////////////////

    assign br_raw = i_flags[I_BEQ]  ? BR_BEQ  : i_flags[I_BNE]  ? BR_BNE  :
                    i_flags[I_BLT]  ? BR_BLT  : i_flags[I_BGE]  ? BR_BGE  :
                    i_flags[I_BLTU] ? BR_BLTU : i_flags[I_BGEU] ? BR_BGEU :
                    i_flags[I_B]    ? BR_B    : i_flags[I_BL]   ? BR_BL   :
                    i_flags[I_JIRL] ? BR_JIRL : BR_NONE;
    assign o_br_type = i_valid ? br_raw : BR_NONE;

    assign o_ldst_type = i_flags[I_LDW]  ? LDST_W_LD  : i_flags[I_STW]  ? LDST_W_ST  :
                         i_flags[I_LDB]  ? LDST_B_LD  : i_flags[I_LDH]  ? LDST_H_LD  :
                         i_flags[I_LDBU] ? LDST_BU_LD : i_flags[I_LDHU] ? LDST_HU_LD :
                         i_flags[I_STB]  ? LDST_B_ST  : i_flags[I_STH]  ? LDST_H_ST  :
                         LDST_OTHER;
    assign o_mem_we = is_store & i_valid;

    assign o_wb_sel = is_load                              ? WB_LD   :
                      i_flags[I_MUL]                       ? WB_MUL  :
                      (i_flags[I_MULH] | i_flags[I_MULHU]) ? WB_MULH :
                      (i_flags[I_DIV] | i_flags[I_DIVU])   ? WB_DIV  :
                      (i_flags[I_MOD] | i_flags[I_MODU])   ? WB_MOD  : WB_ALU;

    assign o_inst_class = (is_load | is_store) ? CLASS_LDST :
                          is_mul ? CLASS_MUL : is_div ? CLASS_DIV : CLASS_OTHER;

    // unsigned forms clear the sign flag
    assign o_sign = ~(i_flags[I_MULHU] | i_flags[I_DIVU] | i_flags[I_MODU]);

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////

    assign o_rf_raddr1 = i_inst.ri.rj;
    // stores and compare branches read rd as the second source
    assign o_rf_raddr2 = (is_store | is_cbr) ? i_inst.ri.rd : i_inst.ri.imm12[4:0];
    // bl links into r1
    assign o_rf_rd     = i_flags[I_BL] ? 5'd1 : i_inst.ri.rd;

    assign o_rf_we = i_valid & i_lawful & ~is_store & ~is_cbr & ~i_flags[I_B]
                   & (o_rf_rd != '0);

endmodule

/* except_gen.sv */
`timescale 1ns/1ps

module except_gen
    import isa_pkg::*;
(
    input  logic [ECODE_W-1:0]  i_ecode,
    input  logic                i_ecode_we,
    input  logic                i_lawful,
    input  logic [NUM_INST-1:0] i_flags,
    output logic [ECODE_W-1:0]  o_ecode,
    output logic                o_ecode_we
);

    always_comb begin
        o_ecode    = ECODE_NONE;
        o_ecode_we = 1'b1;
        // an exception from fetch wins over anything found here
        if (i_ecode_we) begin
            o_ecode = i_ecode;
        end else if (!i_lawful) begin
            o_ecode = ECODE_INE;
        end else if (i_flags[I_BREAK]) begin
            o_ecode = ECODE_BRK;
        end else if (i_flags[I_SYSCALL]) begin
            o_ecode = ECODE_SYS;
        end else begin
            o_ecode_we = 1'b0;
        end
    end

endmodule

/* id_decode.sv */
`timescale 1ns/1ps

module id_decode
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic [XLEN-1:0]       i_inst,
    input  logic [XLEN-1:0]       i_pc,
    input  logic                  i_valid,
    input  logic [ECODE_W:0]      i_ecode_in,
    output logic                  o_valid,
    output logic [XLEN-1:0]       o_inst,
    output logic [XLEN-1:0]       o_pc,
    output logic                  o_lawful,
    output logic [XLEN-1:0]       o_imm,
    output logic [ALU_OP_W-1:0]   o_alu_op,
    output logic [SRC_SEL_W-1:0]  o_src1_sel,
    output logic [SRC_SEL_W-1:0]  o_src2_sel,
    output logic [BR_TYPE_W-1:0]  o_br_type,
    output logic [LDST_W-1:0]     o_ldst_type,
    output logic                  o_mem_we,
    output logic [WB_SEL_W-1:0]   o_wb_sel,
    output logic [CLASS_W-1:0]    o_inst_class,
    output logic                  o_sign,
    output logic [REG_ADDR_W-1:0] o_rf_raddr1,
    output logic [REG_ADDR_W-1:0] o_rf_raddr2,
    output logic [REG_ADDR_W-1:0] o_rf_rd,
    output logic                  o_rf_we,
    output logic [ECODE_W-1:0]    o_ecode,
    output logic                  o_ecode_we
);

    inst_word_t            inst_w;
    logic [NUM_INST-1:0]   flags;
    logic                  lawful;
    logic [XLEN-1:0]       imm;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [SRC_SEL_W-1:0]  src1_sel;
    logic [SRC_SEL_W-1:0]  src2_sel;
    logic [BR_TYPE_W-1:0]  br_type;
    logic [LDST_W-1:0]     ldst_type;
    logic                  mem_we;
    logic [WB_SEL_W-1:0]   wb_sel;
    logic [CLASS_W-1:0]    inst_class;
    logic                  sign;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [REG_ADDR_W-1:0] rf_rd;
    logic                  rf_we;
    logic [ECODE_W-1:0]    ecode;
    logic                  ecode_we;

    assign inst_w = i_inst;

    inst_match match_i (.i_inst(inst_w), .o_flags(flags), .o_lawful(lawful));

    imm_gen imm_i (.i_inst(inst_w), .i_flags(flags), .o_imm(imm));

    ctrl_gen ctrl_i (
        .i_inst(inst_w), .i_flags(flags), .i_lawful(lawful), .i_valid(i_valid),
        .o_alu_op(alu_op), .o_src1_sel(src1_sel), .o_src2_sel(src2_sel),
        .o_br_type(br_type), .o_ldst_type(ldst_type), .o_mem_we(mem_we),
        .o_wb_sel(wb_sel), .o_inst_class(inst_class), .o_sign(sign),
        .o_rf_raddr1(rf_raddr1), .o_rf_raddr2(rf_raddr2),
        .o_rf_rd(rf_rd), .o_rf_we(rf_we)
    );

    // top bit of the incoming field is its write flag
    except_gen except_i (
        .i_ecode(i_ecode_in[ECODE_W-1:0]), .i_ecode_we(i_ecode_in[ECODE_W]),
        .i_lawful(lawful), .i_flags(flags),
        .o_ecode(ecode), .o_ecode_we(ecode_we)
    );

    //////////////////////////////////////////////////////////////////////
    // decode to execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid    <= 1'b0;
            o_rf_we    <= 1'b0;
            o_mem_we   <= 1'b0;
            o_ecode_we <= 1'b0;
            o_br_type  <= BR_NONE;
        end else begin
            o_valid    <= i_valid;
            o_rf_we    <= rf_we;
            o_mem_we   <= mem_we;
            o_ecode_we <= ecode_we;
            o_br_type  <= br_type;
        end
    end

    // payload fields
    always_ff @(posedge i_clk) begin
        o_inst       <= i_inst;
        o_pc         <= i_pc;
        o_lawful     <= lawful;
        o_imm        <= imm;
        o_alu_op     <= alu_op;
        o_src1_sel   <= src1_sel;
        o_src2_sel   <= src2_sel;
        o_ldst_type  <= ldst_type;
        o_wb_sel     <= wb_sel;
        o_inst_class <= inst_class;
        o_sign       <= sign;
        o_rf_raddr1  <= rf_raddr1;
        o_rf_raddr2  <= rf_raddr2;
        o_rf_rd      <= rf_rd;
        o_ecode      <= ecode;
    end

endmodule

/* tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// instruction ids of the model, grouped by opcode width
localparam int
    M_ADD  = 0,  M_SUB  = 1,  M_SLT  = 2,  M_SLTU  = 3,  M_NOR     = 4,
    M_AND  = 5,  M_OR   = 6,  M_XOR  = 7,  M_SLL   = 8,  M_SRL     = 9,
    M_SRA  = 10, M_MUL  = 11, M_MULH = 12, M_MULHU = 13, M_DIV     = 14,
    M_MOD  = 15, M_DIVU = 16, M_MODU = 17, M_BREAK = 18, M_SYSCALL = 19,
    M_SLLI = 20, M_SRLI = 21, M_SRAI = 22,
    M_SLTI = 23, M_SLTUI = 24, M_ADDI = 25, M_ANDI = 26, M_ORI  = 27,
    M_XORI = 28, M_LDB   = 29, M_LDH  = 30, M_LDW  = 31, M_STB  = 32,
    M_STH  = 33, M_STW   = 34, M_LDBU = 35, M_LDHU = 36,
    M_LU12I = 37, M_PCADDU12I = 38,
    M_JIRL = 39, M_B = 40, M_BL = 41, M_BEQ = 42, M_BNE = 43,
    M_BLT  = 44, M_BGE = 45, M_BLTU = 46, M_BGEU = 47;
localparam int M_COUNT = 48;

// opcode value of each id, right aligned
localparam logic [16:0] OPV [M_COUNT] = '{
    17'h020, 17'h022, 17'h024, 17'h025, 17'h028, 17'h029, 17'h02a, 17'h02b,
    17'h02e, 17'h02f, 17'h030, 17'h038, 17'h039, 17'h03a, 17'h040, 17'h041,
    17'h042, 17'h043, 17'h054, 17'h056, 17'h081, 17'h089, 17'h091,
    17'h008, 17'h009, 17'h00a, 17'h00d, 17'h00e, 17'h00f, 17'h0a0, 17'h0a1,
    17'h0a2, 17'h0a4, 17'h0a5, 17'h0a6, 17'h0a8, 17'h0a9,
    17'h00a, 17'h00e,
    17'h013, 17'h014, 17'h015, 17'h016, 17'h017, 17'h018, 17'h019, 17'h01a, 17'h01b
};

logic                  exp_valid;
logic [31:0]           exp_inst;
logic [31:0]           exp_pc;
logic                  exp_lawful;
logic [31:0]           exp_imm;
logic [ALU_OP_W-1:0]   exp_alu_op;
logic [SRC_SEL_W-1:0]  exp_src1_sel;
logic [SRC_SEL_W-1:0]  exp_src2_sel;
logic [BR_TYPE_W-1:0]  exp_br_type;
logic [LDST_W-1:0]     exp_ldst_type;
logic                  exp_mem_we;
logic [WB_SEL_W-1:0]   exp_wb_sel;
logic [CLASS_W-1:0]    exp_inst_class;
logic                  exp_sign;
logic [4:0]            exp_rf_raddr1;
logic [4:0]            exp_rf_raddr2;
logic [4:0]            exp_rf_rd;
logic                  exp_rf_we;
logic [ECODE_W-1:0]    exp_ecode;
logic                  exp_ecode_we;

function automatic int opcode_width(int id);
    if (id < M_SLTI) return 17;
    else if (id < M_LU12I) return 10;
    else if (id < M_JIRL) return 7;
    return 6;
endfunction

// -1 for a word that matches no opcode
function automatic int find_inst(logic [31:0] w);
    int hit;
    hit = -1;
    for (int id = 0; id < M_COUNT; id++) begin
        if ((w >> (32 - opcode_width(id))) == {15'd0, OPV[id]}) begin
            hit = id;
        end
    end
    return hit;
endfunction

task automatic model_decode(input logic [31:0] w, input logic valid, input logic [7:0] ecode_in);
    int   id;
    logic law;
    logic ld;
    logic st;
    logic cbr;
    id  = find_inst(w);
    law = (id >= 0);
    ld  = (id >= M_LDB && id <= M_LDW) || id == M_LDBU || id == M_LDHU;
    st  = (id >= M_STB && id <= M_STW);
    cbr = (id >= M_BEQ);

    exp_valid  = valid;
    exp_inst   = w;
    exp_pc     = i_pc;
    exp_lawful = law;

    //////////////////////////////////////////////////////////////////////
    // immediate formats
    //////////////////////////////////////////////////////////////////////
    if (cbr || id == M_JIRL) begin
        exp_imm = {{14{w[25]}}, w[25:10], 2'b00};
    end else if (id == M_B || id == M_BL) begin
        exp_imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
    end else if (ld || st || id inside {M_SLTI, M_SLTUI, M_ADDI}) begin
        exp_imm = {{20{w[21]}}, w[21:10]};
    end else if (id inside {M_ANDI, M_ORI, M_XORI}) begin
        exp_imm = {20'd0, w[21:10]};
    end else if (id == M_LU12I || id == M_PCADDU12I) begin
        exp_imm = {w[24:5], 12'h000};
    end else if (id >= M_SLLI && id <= M_SRAI) begin
        exp_imm = {27'd0, w[14:10]};
    end else begin
        exp_imm = 32'd0;
    end

    //////////////////////////////////////////////////////////////////////
    // alu and operands
    //////////////////////////////////////////////////////////////////////
    if (ld || st || id inside {M_ADD, M_ADDI, M_PCADDU12I, M_LU12I, M_BL, M_JIRL})
        exp_alu_op = ALU_ADD;
    else if (id inside {M_SUB, M_BEQ, M_BNE})
        exp_alu_op = ALU_SUB;
    else if (id inside {M_SLT, M_SLTI, M_BLT, M_BGE})
        exp_alu_op = ALU_SLT;
    else if (id inside {M_SLTU, M_SLTUI, M_BLTU, M_BGEU})
        exp_alu_op = ALU_SLTU;
    else if (id inside {M_AND, M_ANDI})
        exp_alu_op = ALU_AND;
    else if (id inside {M_OR, M_ORI})
        exp_alu_op = ALU_OR;
    else if (id == M_NOR)
        exp_alu_op = ALU_NOR;
    else if (id inside {M_XOR, M_XORI})
        exp_alu_op = ALU_XOR;
    else if (id inside {M_SLL, M_SLLI})
        exp_alu_op = ALU_SLL;
    else if (id inside {M_SRL, M_SRLI})
        exp_alu_op = ALU_SRL;
    else if (id inside {M_SRA, M_SRAI})
        exp_alu_op = ALU_SRA;
    else
        exp_alu_op = ALU_NONE;

    if (id inside {M_BL, M_PCADDU12I, M_JIRL}) exp_src1_sel = SRC1_PC;
    else if (id == M_LU12I) exp_src1_sel = SRC1_ZERO;
    else exp_src1_sel = SRC1_RF;

    if ((id >= M_SLTI && id <= M_LDHU) || (id >= M_SLLI && id <= M_SRAI)
        || id == M_LU12I || id == M_PCADDU12I)
        exp_src2_sel = SRC2_IMM;
    else if ((id >= M_ADD && id <= M_MODU) || cbr)
        exp_src2_sel = SRC2_RF;
    else
        exp_src2_sel = SRC2_FOUR;

    //////////////////////////////////////////////////////////////////////
    // branch, memory, writeback
    //////////////////////////////////////////////////////////////////////
    case (id)
        M_BEQ:   exp_br_type = BR_BEQ;
        M_BNE:   exp_br_type = BR_BNE;
        M_BLT:   exp_br_type = BR_BLT;
        M_BGE:   exp_br_type = BR_BGE;
        M_BLTU:  exp_br_type = BR_BLTU;
        M_BGEU:  exp_br_type = BR_BGEU;
        M_B:     exp_br_type = BR_B;
        M_BL:    exp_br_type = BR_BL;
        M_JIRL:  exp_br_type = BR_JIRL;
        default: exp_br_type = BR_NONE;
    endcase
    if (!valid) exp_br_type = BR_NONE;

    case (id)
        M_LDW:   exp_ldst_type = LDST_W_LD;
        M_STW:   exp_ldst_type = LDST_W_ST;
        M_LDB:   exp_ldst_type = LDST_B_LD;
        M_LDH:   exp_ldst_type = LDST_H_LD;
        M_LDBU:  exp_ldst_type = LDST_BU_LD;
        M_LDHU:  exp_ldst_type = LDST_HU_LD;
        M_STB:   exp_ldst_type = LDST_B_ST;
        M_STH:   exp_ldst_type = LDST_H_ST;
        default: exp_ldst_type = LDST_OTHER;
    endcase
    exp_mem_we = st && valid;

    if (ld) exp_wb_sel = WB_LD;
    else if (id == M_MUL) exp_wb_sel = WB_MUL;
    else if (id inside {M_MULH, M_MULHU}) exp_wb_sel = WB_MULH;
    else if (id inside {M_DIV, M_DIVU}) exp_wb_sel = WB_DIV;
    else if (id inside {M_MOD, M_MODU}) exp_wb_sel = WB_MOD;
    else exp_wb_sel = WB_ALU;

    if (ld || st) exp_inst_class = CLASS_LDST;
    else if (id >= M_MUL && id <= M_MULHU) exp_inst_class = CLASS_MUL;
    else if (id >= M_DIV && id <= M_MODU) exp_inst_class = CLASS_DIV;
    else exp_inst_class = CLASS_OTHER;

    exp_sign = !(id inside {M_MULHU, M_DIVU, M_MODU});

    // register file ports
    exp_rf_raddr1 = w[9:5];
    exp_rf_raddr2 = (st || cbr) ? w[4:0] : w[14:10];
    exp_rf_rd     = (id == M_BL) ? 5'd1 : w[4:0];
    exp_rf_we     = valid && law && !st && !cbr && id != M_B && exp_rf_rd != 5'd0;

    // earlier exception first, then ine, brk, sys
    exp_ecode_we = 1'b1;
    if (ecode_in[7]) begin
        exp_ecode = ecode_in[6:0];
    end else if (!law) begin
        exp_ecode = ECODE_INE;
    end else if (id == M_BREAK) begin
        exp_ecode = ECODE_BRK;
    end else if (id == M_SYSCALL) begin
        exp_ecode = ECODE_SYS;
    end else begin
        exp_ecode    = ECODE_NONE;
        exp_ecode_we = 1'b0;
    end
endtask

`endif

/* tb_id_decode.sv */
`timescale 1ns/1ps

module tb_id_decode
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int NUM_WORDS   = 2000;
    localparam int WATCHDOG_NS = (NUM_WORDS + 3 + 50) * 100;

    logic                  i_clk;
    logic                  i_reset;
    logic [XLEN-1:0]       i_inst;
    logic [XLEN-1:0]       i_pc;
    logic                  i_valid;
    logic [ECODE_W:0]      i_ecode_in;
    logic                  o_valid;
    logic [XLEN-1:0]       o_inst;
    logic [XLEN-1:0]       o_pc;
    logic                  o_lawful;
    logic [XLEN-1:0]       o_imm;
    logic [ALU_OP_W-1:0]   o_alu_op;
    logic [SRC_SEL_W-1:0]  o_src1_sel;
    logic [SRC_SEL_W-1:0]  o_src2_sel;
    logic [BR_TYPE_W-1:0]  o_br_type;
    logic [LDST_W-1:0]     o_ldst_type;
    logic                  o_mem_we;
    logic [WB_SEL_W-1:0]   o_wb_sel;
    logic [CLASS_W-1:0]    o_inst_class;
    logic                  o_sign;
    logic [REG_ADDR_W-1:0] o_rf_raddr1;
    logic [REG_ADDR_W-1:0] o_rf_raddr2;
    logic [REG_ADDR_W-1:0] o_rf_rd;
    logic                  o_rf_we;
    logic [ECODE_W-1:0]    o_ecode;
    logic                  o_ecode_we;

    int errors;
    int checks;

    `include "tb_model.svh"

    id_decode dut_i (.*);

    always #50 i_clk = ~i_clk;

    //////////////////////////////////////////////////////////////////////
    // stimulus and checking helpers
    //////////////////////////////////////////////////////////////////////

    // three in four words carry a known opcode
    task automatic drive_word();
        int          id;
        int          opw;
        logic [31:0] w;
        w = $urandom;
        if ($urandom % 4 != 0) begin
            id  = int'($urandom % M_COUNT);
            opw = opcode_width(id);
            w   = (w & (32'hffff_ffff >> opw)) | ({15'd0, OPV[id]} << (32 - opw));
        end
        i_inst     <= w;
        i_pc       <= $urandom;
        i_valid    <= ($urandom % 4) != 0;
        i_ecode_in <= {($urandom % 8) == 0, 7'($urandom)};
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reset_levels_low();
        compare_field("valid in reset", 32'(o_valid), 32'd0);
        compare_field("rf_we in reset", 32'(o_rf_we), 32'd0);
        compare_field("mem_we in reset", 32'(o_mem_we), 32'd0);
        compare_field("ecode_we in reset", 32'(o_ecode_we), 32'd0);
        compare_field("br_type in reset", 32'(o_br_type), 32'(BR_NONE));
    endtask

    task automatic verify_outputs();
        compare_field("valid", 32'(o_valid), 32'(exp_valid));
        compare_field("inst", o_inst, exp_inst);
        compare_field("pc", o_pc, exp_pc);
        compare_field("lawful", 32'(o_lawful), 32'(exp_lawful));
        compare_field("imm", o_imm, exp_imm);
        compare_field("alu_op", 32'(o_alu_op), 32'(exp_alu_op));
        compare_field("src1_sel", 32'(o_src1_sel), 32'(exp_src1_sel));
        compare_field("src2_sel", 32'(o_src2_sel), 32'(exp_src2_sel));
        compare_field("br_type", 32'(o_br_type), 32'(exp_br_type));
        compare_field("ldst_type", 32'(o_ldst_type), 32'(exp_ldst_type));
        compare_field("mem_we", 32'(o_mem_we), 32'(exp_mem_we));
        compare_field("wb_sel", 32'(o_wb_sel), 32'(exp_wb_sel));
        compare_field("inst_class", 32'(o_inst_class), 32'(exp_inst_class));
        compare_field("sign", 32'(o_sign), 32'(exp_sign));
        compare_field("rf_raddr1", 32'(o_rf_raddr1), 32'(exp_rf_raddr1));
        compare_field("rf_raddr2", 32'(o_rf_raddr2), 32'(exp_rf_raddr2));
        compare_field("rf_rd", 32'(o_rf_rd), 32'(exp_rf_rd));
        compare_field("rf_we", 32'(o_rf_we), 32'(exp_rf_we));
        compare_field("ecode", 32'(o_ecode), 32'(exp_ecode));
        compare_field("ecode_we", 32'(o_ecode_we), 32'(exp_ecode_we));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_inst     = '0;
        i_pc       = '0;
        i_valid    = 1'b0;
        i_ecode_in = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(32'hea5e_79ae));

        // random words keep arriving while reset is held
        repeat (2) begin
            @(posedge i_clk);
            drive_word();
            @(negedge i_clk);
            reset_levels_low();
        end

        // outputs at each falling edge belong to the word of the cycle before
        for (int k = 0; k < NUM_WORDS; k++) begin
            @(posedge i_clk);
            if (k == 0) begin
                i_reset <= 1'b0;
            end
            drive_word();
            @(negedge i_clk);
            if (k == 0) begin
                reset_levels_low();
            end else begin
                verify_outputs();
            end
            model_decode(i_inst, i_valid, i_ecode_in);
        end
        @(posedge i_clk);
        @(negedge i_clk);
        verify_outputs();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the decode test did not complete in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
inst_match.sv
imm_gen.sv
ctrl_gen.sv
except_gen.sv
id_decode.sv
tb_id_decode.sv

/* Makefile */
# Verilator flow for the decode stage testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module tb_id_decode

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_id_decode -Mdir obj_dir
	./obj_dir/Vtb_id_decode | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
